// ==== sprite_pkg.sv ====
// ==============================
// shared widths and word layouts for the sprite engine
// imported by every sprite module and the hit list interface
// ==============================
`default_nettype none

package sprite_pkg;

    localparam int VRAM_AW = 14;
    localparam int X_W     = 10;
    localparam int Y_W     = 9;

    // one enable bit per attribute table in meta_block_select
    localparam int BLOCK_X = 0;
    localparam int BLOCK_Y = 1;
    localparam int BLOCK_G = 2;

    typedef struct packed {
        logic [3:0]     spare;
        logic           wide;
        logic           tall;
        logic           flip_y;
        logic [Y_W-1:0] sprite_y;
    } y_attr_t;

    typedef struct packed {
        logic [4:0]     spare;
        logic           flip_x;
        logic [X_W-1:0] sprite_x;
    } x_attr_t;

    typedef struct packed {
        logic [3:0] palette;
        logic [1:0] prio;
        logic [9:0] character;
    } g_attr_t;

    // host word, read back through whichever layout the table owns
    typedef union packed {
        y_attr_t y;
        x_attr_t x;
        g_attr_t g;
    } attr_word_t;

    typedef struct packed {
        logic       terminator;
        logic [1:0] spare;
        logic       wide;
        logic [3:0] row;
        logic [7:0] id;
    } hit_entry_t;

    typedef struct packed {
        logic [1:0] spare;
        logic [1:0] prio;
        logic [7:0] index;
    } line_pixel_t;

endpackage

`default_nettype wire

// ==== sprite_hit_list_if.sv ====
// ==============================
// hit list port bundle
// scanner writes, renderer reads, store owns the RAM
// ==============================
`default_nettype none

interface sprite_hit_list_if #(
    parameter int MAX_LINE_SPRITES = 16
);
    import sprite_pkg::*;

    localparam int AW = $clog2(MAX_LINE_SPRITES);

    logic          wr_en;
    logic [AW-1:0] wr_addr;
    hit_entry_t    wr_data;
    logic [AW-1:0] rd_addr;
    hit_entry_t    rd_data;

    modport writer (output wr_en, wr_addr, wr_data);
    modport reader (output rd_addr, input rd_data);
    modport store  (input wr_en, wr_addr, wr_data, rd_addr, output rd_data);

endinterface

`default_nettype wire

// ==== sprite_attr_tables.sv ====
// ==============================
// Y, X and graphics attribute RAMs
// host writes by block select, scanner and renderer read with one cycle latency
// ==============================
`default_nettype none

module sprite_attr_tables #(
    parameter int SPRITE_COUNT = 64
) (
    input  logic                   clk,
    input  logic [7:0]             meta_address,
    input  sprite_pkg::attr_word_t meta_write_data,
    input  logic [2:0]             meta_block_select,
    input  logic                   meta_we,
    input  logic [7:0]             y_rd_addr,
    input  logic [7:0]             xg_rd_addr,
    output sprite_pkg::attr_word_t y_rd_data,
    output sprite_pkg::attr_word_t x_rd_data,
    output sprite_pkg::attr_word_t g_rd_data
);
    import sprite_pkg::*;

    localparam int AW = $clog2(SPRITE_COUNT);

    attr_word_t table_ram [3][SPRITE_COUNT];
    logic       addr_ok;

    // writes past the table depth are dropped
    assign addr_ok = int'(meta_address) < SPRITE_COUNT;

    always_ff @(posedge clk) begin
        for (int b = 0; b < 3; b++) begin
            if (meta_we && meta_block_select[b] && addr_ok) begin
                table_ram[b][meta_address[AW-1:0]] <= meta_write_data;
            end
        end
        y_rd_data <= table_ram[BLOCK_Y][y_rd_addr[AW-1:0]];
        // X and G are always fetched together for one sprite
        x_rd_data <= table_ram[BLOCK_X][xg_rd_addr[AW-1:0]];
        g_rd_data <= table_ram[BLOCK_G][xg_rd_addr[AW-1:0]];
    end

endmodule

`default_nettype wire

// ==== sprite_hit_list.sv ====
// ==============================
// double-banked hit list, bank picked by line parity
// read data is registered
// ==============================
`default_nettype none

module sprite_hit_list #(
    parameter int MAX_LINE_SPRITES = 16
) (
    input  logic             clk,
    input  logic             parity,
    sprite_hit_list_if.store hl
);
    import sprite_pkg::*;

    // scanner fills bank parity, renderer drains the other one
    hit_entry_t bank [2][MAX_LINE_SPRITES];

    always_ff @(posedge clk) begin
        if (hl.wr_en) begin
            bank[parity][hl.wr_addr] <= hl.wr_data;
        end
        hl.rd_data <= bank[!parity][hl.rd_addr];
    end

endmodule

`default_nettype wire

// ==== sprite_raster_collision.sv ====
// ==============================
// per-line sprite scan against the next raster row
// writes hits in ID order, then a terminator if room is left
// ==============================
`default_nettype none

module sprite_raster_collision #(
    parameter int SPRITE_COUNT     = 64,
    parameter int MAX_LINE_SPRITES = 16
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       restart,
    input  logic [sprite_pkg::Y_W-1:0] raster_y,
    output logic [7:0]                 y_rd_addr,
    input  sprite_pkg::attr_word_t     y_rd_data,
    sprite_hit_list_if.writer          hl
);
    import sprite_pkg::*;

    localparam int AW = $clog2(MAX_LINE_SPRITES);

    logic           scanning;
    logic           rd_valid;
    logic           rd_last;
    logic [7:0]     rd_id;
    logic           term_pend;
    logic [AW:0]    hit_count;
    logic [Y_W-1:0] target_y;
    logic [Y_W-1:0] diff;
    logic           full;
    logic           do_hit;
    logic           do_term;
    hit_entry_t     entry;

    // the list built now is drawn during the next line
    assign target_y = raster_y + 1'b1;
    assign diff     = target_y - y_rd_data.y.sprite_y;
    assign full     = int'(hit_count) == MAX_LINE_SPRITES;

    // modulo 512 distance below the sprite height of 8 or 16
    assign do_hit  = rd_valid && !full && diff[Y_W-1:4] == '0 &&
                     (y_rd_data.y.tall || !diff[3]);
    assign do_term = term_pend && !full;

    always_comb begin
        entry      = '0;
        entry.id   = rd_id;
        entry.wide = y_rd_data.y.wide;
        // flip mirrors within 8 or 16 rows
        entry.row  = diff[3:0] ^ ({y_rd_data.y.tall, 3'b111} & {4{y_rd_data.y.flip_y}});
        if (term_pend) begin
            entry            = '0;
            entry.terminator = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scanning  <= 1'b0;
            y_rd_addr <= '0;
            rd_valid  <= 1'b0;
            rd_last   <= 1'b0;
            term_pend <= 1'b0;
            hit_count <= '0;
            hl.wr_en  <= 1'b0;
        end else if (restart) begin
            scanning  <= 1'b1;
            y_rd_addr <= '0;
            rd_valid  <= 1'b0;
            rd_last   <= 1'b0;
            term_pend <= 1'b0;
            hit_count <= '0;
            hl.wr_en  <= 1'b0;
        end else begin
            // table data lags the address by one cycle
            rd_valid  <= scanning;
            rd_last   <= scanning && int'(y_rd_addr) == SPRITE_COUNT - 1;
            term_pend <= rd_valid && rd_last;
            hl.wr_en  <= do_hit || do_term;
            if (do_hit) begin
                hit_count <= hit_count + 1'b1;
            end
            if (scanning) begin
                if (int'(y_rd_addr) == SPRITE_COUNT - 1) begin
                    scanning <= 1'b0;
                end else begin
                    y_rd_addr <= y_rd_addr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_id      <= y_rd_addr;
        hl.wr_addr <= hit_count[AW-1:0];
        hl.wr_data <= entry;
    end

endmodule

`default_nettype wire

// ==== sprite_render.sv ====
// ==============================
// hit list walker and pixel blitter
// fetches 4bpp rows from VRAM and writes opaque pixels to the line buffer
// ==============================
`default_nettype none

module sprite_render #(
    parameter int MAX_LINE_SPRITES = 16
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           restart,
    input  logic [sprite_pkg::VRAM_AW-1:0] vram_base_address,
    output logic [sprite_pkg::VRAM_AW-1:0] vram_read_address,
    output logic                           vram_read_en,
    input  logic [31:0]                    vram_read_data,
    input  logic                           vram_data_valid,
    output logic [7:0]                     xg_rd_addr,
    input  sprite_pkg::attr_word_t         x_rd_data,
    input  sprite_pkg::attr_word_t         g_rd_data,
    sprite_hit_list_if.reader              hl,
    output logic                           line_wr_en,
    output logic [sprite_pkg::X_W-1:0]     line_wr_addr,
    output sprite_pkg::line_pixel_t        line_wr_data
);
    import sprite_pkg::*;

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_LIST  = 3'd1;
    localparam logic [2:0] S_ENTRY = 3'd2;
    localparam logic [2:0] S_ATTR  = 3'd3;
    localparam logic [2:0] S_FETCH = 3'd4;
    localparam logic [2:0] S_WAIT  = 3'd5;
    localparam logic [2:0] S_DRAW  = 3'd6;

    logic [2:0]     state;
    logic           half;
    logic [2:0]     col;
    logic [3:0]     row;
    logic           wide;
    logic [X_W-1:0] spr_x;
    logic           flip_x;
    logic [8:0]     char_base;
    logic [3:0]     palette;
    logic [1:0]     prio;
    logic [31:0]    word;
    logic [3:0]     column;
    logic           last_entry;

    // attribute address comes straight off the registered hit list output
    assign xg_rd_addr = hl.rd_data.id;
    // flip reverses across the whole 8 or 16 pixel sprite
    assign column     = {half, col} ^ ({wide, 3'b111} & {4{flip_x}});
    assign last_entry = int'(hl.rd_addr) == MAX_LINE_SPRITES - 1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= S_IDLE;
            hl.rd_addr   <= '0;
            half         <= 1'b0;
            col          <= '0;
            vram_read_en <= 1'b0;
            line_wr_en   <= 1'b0;
        end else begin
            vram_read_en <= 1'b0;
            line_wr_en   <= 1'b0;
            if (restart) begin
                state      <= S_LIST;
                hl.rd_addr <= '0;
            end else begin
                case (state)
                    S_LIST: begin
                        state <= S_ENTRY;
                    end
                    S_ENTRY: begin
                        state <= hl.rd_data.terminator ? S_IDLE : S_ATTR;
                    end
                    S_ATTR: begin
                        half  <= 1'b0;
                        state <= S_FETCH;
                    end
                    S_FETCH: begin
                        vram_read_en <= 1'b1;
                        state        <= S_WAIT;
                    end
                    S_WAIT: begin
                        if (vram_data_valid) begin
                            col   <= '0;
                            state <= S_DRAW;
                        end
                    end
                    S_DRAW: begin
                        // nibble 0 is transparent
                        line_wr_en <= word[3:0] != 4'd0;
                        col        <= col + 1'b1;
                        if (col == 3'd7) begin
                            if (wide && !half) begin
                                half  <= 1'b1;
                                state <= S_FETCH;
                            end else if (last_entry) begin
                                state <= S_IDLE;
                            end else begin
                                hl.rd_addr <= hl.rd_addr + 1'b1;
                                state      <= S_LIST;
                            end
                        end
                    end
                    default: begin
                        state <= S_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_ENTRY: begin
                row  <= hl.rd_data.row;
                wide <= hl.rd_data.wide;
            end
            S_ATTR: begin
                spr_x     <= x_rd_data.x.sprite_x;
                flip_x    <= x_rd_data.x.flip_x;
                // character bit 9 falls outside the 14 bit VRAM space
                char_base <= g_rd_data.g.character[8:0];
                palette   <= g_rd_data.g.palette;
                prio      <= g_rd_data.g.prio;
            end
            S_FETCH: begin
                // 32 words per character, 2 words per row
                vram_read_address <= vram_base_address + {char_base, 5'd0} +
                                     {9'd0, row, half};
            end
            S_WAIT: begin
                word <= vram_read_data;
            end
            S_DRAW: begin
                // pixel k is nibble k, lowest nibble leftmost
                word               <= word >> 4;
                line_wr_addr       <= spr_x + X_W'(column);
                line_wr_data.spare <= '0;
                line_wr_data.prio  <= prio;
                line_wr_data.index <= {palette, word[3:0]};
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== sprite_line_buffer.sv ====
// ==============================
// double line buffer between renderer and display
// onscreen half is read at x and zeroed behind the read
// ==============================
`default_nettype none

module sprite_line_buffer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       parity,
    input  logic [sprite_pkg::X_W-1:0] x,
    input  logic                       line_wr_en,
    input  logic [sprite_pkg::X_W-1:0] line_wr_addr,
    input  sprite_pkg::line_pixel_t    line_wr_data,
    output logic [7:0]                 pixel,
    output logic [1:0]                 pixel_priority
);
    import sprite_pkg::*;

    // buffer[parity] is offscreen, buffer[!parity] onscreen
    line_pixel_t    buffer [2][2**X_W];
    line_pixel_t    out_q;
    logic [X_W-1:0] clr_addr;
    logic           clr_bank;

    always_ff @(posedge clk) begin
        // clear goes to the half it was read from, even across a parity flip
        buffer[clr_bank][clr_addr] <= '0;
        if (line_wr_en) begin
            buffer[parity][line_wr_addr] <= line_wr_data;
        end
        clr_addr <= x;
        clr_bank <= !parity;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_q <= '0;
        end else begin
            out_q <= buffer[!parity][x];
        end
    end

    assign pixel          = out_q.index;
    assign pixel_priority = out_q.prio;

endmodule

`default_nettype wire

// ==== sprite_core.sv ====
// ==============================
// sprite engine top level
// attribute tables, scanner, hit list, renderer and line buffer
// ==============================
`default_nettype none

module sprite_core #(
    parameter int SPRITE_COUNT     = 64,
    parameter int MAX_LINE_SPRITES = 16
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           start_new_line,
    input  logic [sprite_pkg::X_W-1:0]     x,
    input  logic [sprite_pkg::Y_W-1:0]     y,
    input  logic [7:0]                     meta_address,
    input  logic [15:0]                    meta_write_data,
    input  logic [2:0]                     meta_block_select,
    input  logic                           meta_we,
    input  logic [sprite_pkg::VRAM_AW-1:0] vram_base_address,
    output logic [sprite_pkg::VRAM_AW-1:0] vram_read_address,
    output logic                           vram_read_en,
    input  logic [31:0]                    vram_read_data,
    input  logic                           vram_data_valid,
    output logic [7:0]                     pixel,
    output logic [1:0]                     pixel_priority
);
    import sprite_pkg::*;

    logic           start_r;
    logic [X_W-1:0] x_r;
    logic           parity;
    logic [7:0]     y_rd_addr;
    logic [7:0]     xg_rd_addr;
    attr_word_t     y_rd_data;
    attr_word_t     x_rd_data;
    attr_word_t     g_rd_data;
    logic           line_wr_en;
    logic [X_W-1:0] line_wr_addr;
    line_pixel_t    line_wr_data;

    sprite_hit_list_if #(.MAX_LINE_SPRITES(MAX_LINE_SPRITES)) hl ();

    // even and odd lines swap hit list banks and line buffer halves
    assign parity = y[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start_r <= 1'b0;
        end else begin
            start_r <= start_new_line;
        end
    end

    always_ff @(posedge clk) begin
        x_r <= x;
    end

    sprite_attr_tables #(.SPRITE_COUNT(SPRITE_COUNT)) u_attr (
        .clk               (clk),
        .meta_address      (meta_address),
        .meta_write_data   (meta_write_data),
        .meta_block_select (meta_block_select),
        .meta_we           (meta_we),
        .y_rd_addr         (y_rd_addr),
        .xg_rd_addr        (xg_rd_addr),
        .y_rd_data         (y_rd_data),
        .x_rd_data         (x_rd_data),
        .g_rd_data         (g_rd_data)
    );

    sprite_raster_collision #(
        .SPRITE_COUNT     (SPRITE_COUNT),
        .MAX_LINE_SPRITES (MAX_LINE_SPRITES)
    ) u_scan (
        .clk       (clk),
        .arst_n    (arst_n),
        .restart   (start_r),
        .raster_y  (y),
        .y_rd_addr (y_rd_addr),
        .y_rd_data (y_rd_data),
        .hl        (hl)
    );

    sprite_hit_list #(.MAX_LINE_SPRITES(MAX_LINE_SPRITES)) u_hit_list (
        .clk    (clk),
        .parity (parity),
        .hl     (hl)
    );

    sprite_render #(.MAX_LINE_SPRITES(MAX_LINE_SPRITES)) u_render (
        .clk               (clk),
        .arst_n            (arst_n),
        .restart           (start_r),
        .vram_base_address (vram_base_address),
        .vram_read_address (vram_read_address),
        .vram_read_en      (vram_read_en),
        .vram_read_data    (vram_read_data),
        .vram_data_valid   (vram_data_valid),
        .xg_rd_addr        (xg_rd_addr),
        .x_rd_data         (x_rd_data),
        .g_rd_data         (g_rd_data),
        .hl                (hl),
        .line_wr_en        (line_wr_en),
        .line_wr_addr      (line_wr_addr),
        .line_wr_data      (line_wr_data)
    );

    sprite_line_buffer u_line_buffer (
        .clk            (clk),
        .arst_n         (arst_n),
        .parity         (parity),
        .x              (x_r),
        .line_wr_en     (line_wr_en),
        .line_wr_addr   (line_wr_addr),
        .line_wr_data   (line_wr_data),
        .pixel          (pixel),
        .pixel_priority (pixel_priority)
    );

endmodule

`default_nettype wire

// ==== sprite_core_sva.sv ====
// ==============================
// protocol assertions for the sprite renderer
// attached to every sprite_render instance by bind
// ==============================
`default_nettype none

module sprite_core_sva (
    input wire logic       clk,
    input wire logic       arst_n,
    input wire logic       restart,
    input wire logic [2:0] state,
    input wire logic       vram_read_en,
    input wire logic       vram_data_valid,
    input wire logic       line_wr_en
);
    timeunit 1ns;
    timeprecision 1ps;

    logic outstanding;

    // one VRAM request in flight until its valid pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= 1'b0;
        end else if (vram_read_en) begin
            outstanding <= 1'b1;
        end else if (vram_data_valid) begin
            outstanding <= 1'b0;
        end
    end

    a_single_request: assert property (@(posedge clk) disable iff (!arst_n)
        vram_read_en |-> !outstanding)
        else $error("VRAM request issued while one is outstanding");

    // state 0 is the idle state of the renderer FSM
    a_idle_at_restart: assert property (@(posedge clk) disable iff (!arst_n)
        restart |-> state == 3'd0)
        else $error("renderer busy when the next line started");

    a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !line_wr_en)
        else $error("line buffer write during reset");

endmodule

bind sprite_render sprite_core_sva u_sva (
    .clk             (clk),
    .arst_n          (arst_n),
    .restart         (restart),
    .state           (state),
    .vram_read_en    (vram_read_en),
    .vram_data_valid (vram_data_valid),
    .line_wr_en      (line_wr_en)
);

`default_nettype wire

// ==== tb_sprite_core.sv ====
// ==============================
// testbench for the sprite engine
// plays VRAM and the video timing, checks every displayed pixel
// against a reference renderer kept per line
// ==============================
`default_nettype none

module tb_sprite_core;
    timeunit 1ns;
    timeprecision 1ps;
    import sprite_pkg::*;

    localparam int SPRITES  = 64;
    localparam int MAX_HITS = 16;
    localparam int SWEEP    = 640;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        start_new_line = 1'b0;
    logic [9:0]  x = '0;
    logic [8:0]  y = '0;
    logic [7:0]  meta_address = '0;
    logic [15:0] meta_write_data = '0;
    logic [2:0]  meta_block_select = '0;
    logic        meta_we = 1'b0;
    logic [13:0] vram_base_address = '0;
    logic [13:0] vram_read_address;
    logic        vram_read_en;
    logic [31:0] vram_read_data = '0;
    logic        vram_data_valid = 1'b0;
    logic [7:0]  pixel;
    logic [1:0]  pixel_priority;

    logic [15:0] stim_lfsr = 16'd51;
    logic [15:0] lat_lfsr = 16'd51;
    logic        vram_busy = 1'b0;
    logic [13:0] vram_addr_q;
    int          vram_wait;
    int          errors = 0;
    int          checks = 0;
    int          line_no = 0;
    int          check_from = 3;
    logic [8:0]  cur_y = '0;

    // model copies of the tables, plus a short per-line history
    logic [15:0] y_tab [SPRITES];
    logic [15:0] x_tab [SPRITES];
    logic [15:0] g_tab [SPRITES];
    logic [15:0] hy [4][SPRITES];
    logic [15:0] hx [4][SPRITES];
    logic [15:0] hg [4][SPRITES];
    logic [13:0] hbase [4];
    logic [8:0]  hrow [4];
    logic [9:0]  exp_px [1024];

    sprite_core #(.SPRITE_COUNT(SPRITES), .MAX_LINE_SPRITES(MAX_HITS)) i_dut (.*);

    initial begin
        forever #10 clk = !clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] vram_word(input logic [13:0] a);
        logic [31:0] h;
        h = {18'd0, a} * 32'h9E37_79B1;
        return h ^ (h >> 15);
    endfunction

    // VRAM answers each request once after 1 to 8 cycles
    always @(negedge clk) begin
        vram_data_valid = 1'b0;
        if (vram_busy) begin
            if (vram_wait == 0) begin
                vram_data_valid = 1'b1;
                vram_read_data  = vram_word(vram_addr_q);
                vram_busy       = 1'b0;
            end else begin
                vram_wait--;
            end
        end
        if (vram_read_en) begin
            if (vram_busy) begin
                $display("VRAM request at %0t arrived while another was outstanding", $time);
                errors++;
            end
            vram_busy   = 1'b1;
            vram_addr_q = vram_read_address;
            vram_wait   = 0;
            for (int i = 0; i < 3; i++) begin
                lat_lfsr  = lfsr_next(lat_lfsr);
                vram_wait = vram_wait * 2 + int'(lat_lfsr[0]);
            end
        end
    end

    task automatic write_attr(input int id, input int blk, input logic [15:0] d);
        @(negedge clk);
        meta_address      = 8'(id);
        meta_block_select = 3'b001 << blk;
        meta_write_data   = d;
        meta_we           = 1'b1;
        @(negedge clk);
        meta_we = 1'b0;
        if (blk == BLOCK_Y) y_tab[id] = d;
        else if (blk == BLOCK_X) x_tab[id] = d;
        else g_tab[id] = d;
    endtask

    // new random sprite; the caller picks its row and column
    task automatic place_sprite(input int id, input logic [8:0] sy, input logic [9:0] sx);
        write_attr(id, BLOCK_Y, {4'd0, 3'(rand_bits(3)), sy});
        write_attr(id, BLOCK_X, {5'd0, 1'(rand_bits(1)), sx});
        write_attr(id, BLOCK_G, 16'(rand_bits(16)));
    endtask

    // moves every sprite half a frame away from the current row
    task automatic park_all();
        for (int id = 0; id < SPRITES; id++) begin
            write_attr(id, BLOCK_Y, {4'd0, 3'(rand_bits(3)), cur_y + 9'd256});
        end
    endtask

    task automatic build_expected(input int s, input int r);
        logic [8:0]  row_y;
        logic [8:0]  d;
        logic [13:0] a;
        logic [31:0] w32;
        logic [3:0]  nib;
        y_attr_t     ya;
        x_attr_t     xa;
        g_attr_t     ga;
        int          hits;
        int          h;
        int          w;
        int          sr;
        int          src;
        for (int i = 0; i < 1024; i++) exp_px[i] = '0;
        row_y = hrow[s] + 9'd1;
        hits  = 0;
        for (int id = 0; id < SPRITES && hits < MAX_HITS; id++) begin
            ya = hy[s][id];
            h  = ya.tall ? 16 : 8;
            d  = row_y - ya.sprite_y;
            if (int'(d) < h) begin
                hits++;
                xa = hx[r][id];
                ga = hg[r][id];
                w  = ya.wide ? 16 : 8;
                sr = ya.flip_y ? h - 1 - int'(d) : int'(d);
                for (int c = 0; c < w; c++) begin
                    src = xa.flip_x ? w - 1 - c : c;
                    a   = hbase[r] + 14'(ga.character * 32) + 14'(sr * 2 + src / 8);
                    w32 = vram_word(a) >> (4 * (src % 8));
                    nib = w32[3:0];
                    if (nib != 4'd0) begin
                        exp_px[(int'(xa.sprite_x) + c) % 1024] = {ga.prio, ga.palette, nib};
                    end
                end
            end
        end
    endtask

    task automatic run_line();
        int         slot;
        int         timer;
        logic [9:0] got;
        timer = 0;
        while (vram_busy || vram_read_en) begin
            @(negedge clk);
            timer++;
            if (timer > 100) begin
                $display("timeout: VRAM request never completed before the line strobe");
                $display("TEST FAILED");
                $finish;
            end
        end
        line_no++;
        cur_y = cur_y + 9'd1;
        slot  = line_no % 4;
        for (int i = 0; i < SPRITES; i++) begin
            hy[slot][i] = y_tab[i];
            hx[slot][i] = x_tab[i];
            hg[slot][i] = g_tab[i];
        end
        hbase[slot] = vram_base_address;
        hrow[slot]  = cur_y;
        @(negedge clk);
        y = cur_y;
        start_new_line = 1'b1;
        @(negedge clk);
        start_new_line = 1'b0;
        // display shows the row scanned two lines back, drawn one line back
        if (line_no >= check_from) build_expected((line_no - 2) % 4, (line_no - 1) % 4);
        for (int c = 0; c < SWEEP + 2; c++) begin
            if (c >= 2 && line_no >= check_from) begin
                got = {pixel_priority, pixel};
                checks++;
                if (got !== exp_px[c - 2]) begin
                    errors++;
                    $display("ERR %0t: y=%0d x=%0d expected %h got %h",
                             $time, cur_y, c - 2, exp_px[c - 2], got);
                end
            end
            // past the sweep x rests on a column that is never shown
            x = (c < SWEEP) ? 10'(c) : 10'd1023;
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
    endtask

    task automatic report(input string name, input int err0, input int chk0);
        $display("%s: %0d pixels checked, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        int e0;
        int c0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        for (int id = 0; id < SPRITES; id++) begin
            write_attr(id, BLOCK_X, 16'(rand_bits(16)));
            write_attr(id, BLOCK_G, 16'(rand_bits(16)));
        end
        park_all();

        e0 = errors;
        c0 = checks;
        repeat (6) run_line();
        report("empty screen", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int k = 0; k < 6; k++) begin
            park_all();
            place_sprite(int'(rand_bits(6)), cur_y + 9'd3, 10'(rand_bits(10)));
            repeat (20) run_line();
        end
        report("single sprites", e0, c0);

        e0 = errors;
        c0 = checks;
        park_all();
        for (int id = 0; id < 10; id++) begin
            place_sprite(id, cur_y + 9'd3 + 9'(rand_bits(3)), 10'd100 + 10'(rand_bits(5)));
        end
        repeat (22) run_line();
        report("overlaps", e0, c0);

        e0 = errors;
        c0 = checks;
        park_all();
        for (int id = 0; id < 24; id++) begin
            place_sprite(id, cur_y + 9'd3, 10'(id * 24) + 10'(rand_bits(3)));
        end
        repeat (20) run_line();
        report("overflow", e0, c0);

        e0 = errors;
        c0 = checks;
        // jump the raster so rows run through 511 and back to 0
        cur_y      = 9'd499;
        check_from = line_no + 3;
        park_all();
        place_sprite(5, 9'd508, 10'd1018);
        place_sprite(9, 9'd2, 10'(rand_bits(10)));
        // sprite 5 is drawn at column 1018 across the row wrap before it moves
        repeat (14) run_line();
        write_attr(5, BLOCK_X, {5'd0, 1'b1, 10'd600});
        write_attr(5, BLOCK_G, 16'(rand_bits(16)));
        vram_base_address = 14'(rand_bits(14));
        repeat (14) run_line();
        report("wrap and update", e0, c0);

        $display("total: %0d pixels checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
sprite_pkg.sv
sprite_hit_list_if.sv
sprite_attr_tables.sv
sprite_hit_list.sv
sprite_raster_collision.sv
sprite_render.sv
sprite_line_buffer.sv
sprite_core.sv
sprite_core_sva.sv
tb_sprite_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sprite engine testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_sprite_core -o sim_sprite_core
./obj_dir/sim_sprite_core > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
    exit 1
fi
exit 0
